// File: common/status_pkg.sv
package status_pkg;

    // width of each event counter and of the response word
    localparam int unsigned COUNT_W = 16;

    // status LED source selection
    typedef enum logic [1:0] {
        LED_AUTO        = 2'd0,
        LED_OPTICAL     = 2'd1,
        LED_CONSOLE     = 2'd2,
        LED_OPTICAL_ALT = 2'd3
    } led_conf_t;

    // flags already synchronous to control_clock
    typedef struct packed {
        logic pll54_locked;
        logic pll_hdmi_locked;
        logic resync;
        logic force_generate;
        logic adv7513_ready;
    } link_status_t;

    typedef struct packed {
        logic [COUNT_W-1:0] pll54_lockloss;
        logic [COUNT_W-1:0] pll_hdmi_lockloss;
        logic [COUNT_W-1:0] resync;
    } event_counts_t;

    // counter select codes, anything else reads as zero
    localparam logic [2:0] CNT_PLL54    = 3'd0;
    localparam logic [2:0] CNT_PLL_HDMI = 3'd1;
    localparam logic [2:0] CNT_RESYNC   = 3'd2;

endpackage

// File: common/ctrl_pkg.sv
package ctrl_pkg;

    localparam int unsigned CMD_W = 16;

    typedef enum logic [3:0] {
        OP_NOP          = 4'h0,
        OP_RESET        = 4'h1,
        OP_SET_LED      = 4'h2,
        OP_READ_COUNTER = 4'h3
    } opcode_t;

    typedef enum logic [1:0] {
        TGT_NONE    = 2'd0,
        TGT_CONSOLE = 2'd1,
        TGT_OPTICAL = 2'd2,
        TGT_BOTH    = 2'd3
    } reset_target_t;

    // payload view for OP_RESET and OP_SET_LED
    typedef struct packed {
        reset_target_t         target;
        status_pkg::led_conf_t led_conf;
        logic [7:0]            reserved;
    } ctrl_args_t;

    // payload view for OP_READ_COUNTER
    typedef struct packed {
        logic [2:0] counter_sel;
        logic [8:0] reserved;
    } read_args_t;

    typedef union packed {
        ctrl_args_t ctrl;
        read_args_t read;
    } cmd_payload_u;

    typedef struct packed {
        opcode_t      opcode;
        cmd_payload_u payload;
    } cmd_word_t;

endpackage

// File: reset/reset_hold.sv
`timescale 1ns/1ps

module reset_hold #(
    parameter int unsigned HOLD_CYCLES    = 32_000_000,
    parameter bit          START_IN_RESET = 1'b1
) (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic start,
    output logic nreset
);

    localparam int unsigned CNT_W = $clog2(HOLD_CYCLES + 1);
    localparam logic [CNT_W-1:0] HOLD_LOAD = CNT_W'(HOLD_CYCLES);

    // cycles left until release
    logic [CNT_W-1:0] remaining;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            remaining <= START_IN_RESET ? HOLD_LOAD : '0;
        end else if (start) begin
            // restart also while a hold is running
            remaining <= HOLD_LOAD;
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    assign nreset = (remaining == '0);

endmodule

// File: status/lockloss_monitor.sv
`timescale 1ns/1ps

module lockloss_monitor (
    input  logic                      control_clock,
    input  logic                      reset_dc,
    input  status_pkg::link_status_t  link,
    output status_pkg::event_counts_t counts
);

    logic prev_pll54_locked;
    logic prev_pll_hdmi_locked;
    logic prev_resync;
    logic pll54_loss;
    logic pll_hdmi_loss;
    logic resync_rise;

    function automatic logic [status_pkg::COUNT_W-1:0] sat_inc(
        input logic [status_pkg::COUNT_W-1:0] value,
        input logic                           hit
    );
        if (hit && (value != '1)) begin
            return value + 1'b1;
        end
        return value;
    endfunction

    // falling lock, rising resync
    assign pll54_loss    = prev_pll54_locked && !link.pll54_locked;
    assign pll_hdmi_loss = prev_pll_hdmi_locked && !link.pll_hdmi_locked;
    assign resync_rise   = !prev_resync && link.resync;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            // assume locked and idle so reset itself counts nothing
            prev_pll54_locked    <= 1'b1;
            prev_pll_hdmi_locked <= 1'b1;
            prev_resync          <= 1'b0;
            counts               <= '0;
        end else begin
            prev_pll54_locked        <= link.pll54_locked;
            prev_pll_hdmi_locked     <= link.pll_hdmi_locked;
            prev_resync              <= link.resync;
            counts.pll54_lockloss    <= sat_inc(counts.pll54_lockloss, pll54_loss);
            counts.pll_hdmi_lockloss <= sat_inc(counts.pll_hdmi_lockloss, pll_hdmi_loss);
            counts.resync            <= sat_inc(counts.resync, resync_rise);
        end
    end

endmodule

// File: status/status_led.sv
`timescale 1ns/1ps

module status_led_drv #(
    parameter int unsigned SLOW_GLOW_BIT = 26,
    parameter int unsigned FAST_GLOW_BIT = 22,
    parameter int unsigned BLINK_BIT     = 24
) (
    input  logic                     control_clock,
    input  logic                     reset_dc,
    input  status_pkg::link_status_t link,
    input  status_pkg::led_conf_t    led_conf,
    input  logic                     dc_nreset,
    input  logic                     opt_nreset,
    output logic                     status_led
);

    localparam int unsigned GLOW_TOP = (SLOW_GLOW_BIT > FAST_GLOW_BIT) ?
                                       SLOW_GLOW_BIT : FAST_GLOW_BIT;
    localparam int unsigned TOP_BIT  = (GLOW_TOP > BLINK_BIT) ? GLOW_TOP : BLINK_BIT;

    logic [TOP_BIT:0] led_count;
    logic             slow_glow;
    logic             fast_glow;
    logic             blink;

    // triangle brightness from the bits below pos, pwm from the low bits
    function automatic logic glow_at(
        input logic [TOP_BIT:0] count,
        input int unsigned      pos
    );
        logic [2:0] level;
        level = count[pos-1 -: 3];
        if (count[pos]) begin
            level = ~level;
        end
        return count[2:0] < level;
    endfunction

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            led_count <= '0;
            slow_glow <= 1'b0;
            fast_glow <= 1'b0;
            blink     <= 1'b0;
        end else begin
            led_count <= led_count + 1'b1;
            slow_glow <= glow_at(led_count, SLOW_GLOW_BIT);
            fast_glow <= glow_at(led_count, FAST_GLOW_BIT);
            blink     <= led_count[BLINK_BIT];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // source selection, LED is active low
    always_comb begin
        case (led_conf)
            status_pkg::LED_CONSOLE: begin
                status_led = dc_nreset;
            end
            status_pkg::LED_OPTICAL,
            status_pkg::LED_OPTICAL_ALT: begin
                status_led = opt_nreset;
            end
            default: begin
                // auto mode, highest priority first
                if (!link.pll_hdmi_locked) begin
                    status_led = 1'b1;
                end else if (link.resync) begin
                    status_led = ~fast_glow;
                end else if (link.force_generate) begin
                    status_led = blink ? ~fast_glow : 1'b1;
                end else if (link.adv7513_ready) begin
                    status_led = 1'b0;
                end else begin
                    status_led = ~slow_glow;
                end
            end
        endcase
    end

endmodule

// File: src/cmd_handler.sv
`timescale 1ns/1ps

module cmd_handler (
    input  logic                           control_clock,
    input  logic                           reset_dc,
    input  logic                           cmd_req,
    input  ctrl_pkg::cmd_word_t            cmd_word,
    input  status_pkg::event_counts_t      counts,
    output logic                           cmd_ack,
    output logic [status_pkg::COUNT_W-1:0] rsp_data,
    output logic                           console_start,
    output logic                           optical_start,
    output status_pkg::led_conf_t          led_conf
);

    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } hs_state_t;

    hs_state_t                      state;
    logic                           accept;
    ctrl_pkg::ctrl_args_t           ctrl_view;
    ctrl_pkg::read_args_t           read_view;
    logic [status_pkg::COUNT_W-1:0] selected_count;
    logic                           hit_console;
    logic                           hit_optical;

    // new command only between complete four-phase cycles
    assign accept = cmd_req && !cmd_ack && (state == ST_IDLE);

    assign ctrl_view = cmd_word.payload.ctrl;
    assign read_view = cmd_word.payload.read;

    assign hit_console = (ctrl_view.target == ctrl_pkg::TGT_CONSOLE) ||
                         (ctrl_view.target == ctrl_pkg::TGT_BOTH);
    assign hit_optical = (ctrl_view.target == ctrl_pkg::TGT_OPTICAL) ||
                         (ctrl_view.target == ctrl_pkg::TGT_BOTH);

    // counter readback mux
    always_comb begin
        case (read_view.counter_sel)
            status_pkg::CNT_PLL54:    selected_count = counts.pll54_lockloss;
            status_pkg::CNT_PLL_HDMI: selected_count = counts.pll_hdmi_lockloss;
            status_pkg::CNT_RESYNC:   selected_count = counts.resync;
            default:                  selected_count = '0;
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            state         <= ST_IDLE;
            cmd_ack       <= 1'b0;
            rsp_data      <= '0;
            console_start <= 1'b0;
            optical_start <= 1'b0;
            led_conf      <= status_pkg::LED_AUTO;
        end else begin
            // start strobes last one cycle
            console_start <= 1'b0;
            optical_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_ACK;
                        case (cmd_word.opcode)
                            ctrl_pkg::OP_RESET: begin
                                console_start <= hit_console;
                                optical_start <= hit_optical;
                                rsp_data      <= '0;
                            end
                            ctrl_pkg::OP_SET_LED: begin
                                led_conf <= ctrl_view.led_conf;
                                rsp_data <= '0;
                            end
                            ctrl_pkg::OP_READ_COUNTER: begin
                                rsp_data <= selected_count;
                            end
                            default: begin
                                rsp_data <= '0;
                            end
                        endcase
                    end
                end
                ST_ACK: begin
                    if (!cmd_ack) begin
                        cmd_ack <= 1'b1;
                    end else if (!cmd_req) begin
                        // host saw the ack, close the cycle
                        cmd_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: src/dc_control.sv
`timescale 1ns/1ps

module dc_control #(
    parameter int unsigned HOLD_CYCLES   = 32_000_000,
    parameter int unsigned SLOW_GLOW_BIT = 26,
    parameter int unsigned FAST_GLOW_BIT = 22,
    parameter int unsigned BLINK_BIT     = 24
) (
    input  logic                           control_clock,
    input  logic                           reset_dc,
    input  logic                           cmd_req,
    input  ctrl_pkg::cmd_word_t            cmd_word,
    output logic                           cmd_ack,
    output logic [status_pkg::COUNT_W-1:0] rsp_data,
    input  status_pkg::link_status_t       link,
    output logic                           dc_nreset,
    output logic                           opt_nreset,
    output logic                           status_led
);

    logic                      console_start;
    logic                      optical_start;
    status_pkg::led_conf_t     led_conf;
    status_pkg::event_counts_t counts;

    cmd_handler cmd_port (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .cmd_req       (cmd_req),
        .cmd_word      (cmd_word),
        .counts        (counts),
        .cmd_ack       (cmd_ack),
        .rsp_data      (rsp_data),
        .console_start (console_start),
        .optical_start (optical_start),
        .led_conf      (led_conf)
    );

    //////////////////////////////////////////////////////////////////////
    // reset holds
    // console is held after system reset, optical drive is not
    reset_hold #(.HOLD_CYCLES(HOLD_CYCLES), .START_IN_RESET(1'b1)) console_hold (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .start         (console_start),
        .nreset        (dc_nreset)
    );

    reset_hold #(.HOLD_CYCLES(HOLD_CYCLES), .START_IN_RESET(1'b0)) optical_hold (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .start         (optical_start),
        .nreset        (opt_nreset)
    );

    //////////////////////////////////////////////////////////////////////
    // status
    lockloss_monitor lockloss_mon (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .link          (link),
        .counts        (counts)
    );

    status_led_drv #(
        .SLOW_GLOW_BIT (SLOW_GLOW_BIT),
        .FAST_GLOW_BIT (FAST_GLOW_BIT),
        .BLINK_BIT     (BLINK_BIT)
    ) led_drv (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .link          (link),
        .led_conf      (led_conf),
        .dc_nreset     (dc_nreset),
        .opt_nreset    (opt_nreset),
        .status_led    (status_led)
    );

endmodule

// File: sim/dc_control_assert.sv
`timescale 1ns/1ps

module dc_control_assert (
    input logic control_clock,
    input logic reset_dc,
    input logic cmd_req,
    input logic cmd_ack,
    input logic dc_nreset
);

    // ack only answers a pending request
    ack_needs_req: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        $rose(cmd_ack) |-> $past(cmd_req)
    ) else $error("cmd_ack rose without cmd_req");

    // four-phase, ack drops only once the host released req
    ack_drop_after_req: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        $fell(cmd_ack) |-> !$past(cmd_req)
    ) else $error("cmd_ack fell while cmd_req was still high");

    // system reset holds the console
    console_held: assert property (
        @(posedge control_clock)
        reset_dc |=> !dc_nreset
    ) else $error("dc_nreset not low in the cycle after reset_dc");

endmodule

// File: sim/tb_dc_control.sv
`timescale 1ns/1ps

module tb_dc_control;

    localparam int unsigned HOLD_CYCLES    = 40;
    localparam int unsigned SLOW_GLOW_BIT  = 7;
    // summed test lengths are near 1000 cycles
    localparam int          TIMEOUT_CYCLES = 3000;
    // slow glow triangle repeats every 2**(SLOW_GLOW_BIT+1) cycles
    localparam int          GLOW_PERIOD    = 2 ** (SLOW_GLOW_BIT + 1);

    logic                           control_clock;
    logic                           reset_dc;
    logic                           cmd_req;
    ctrl_pkg::cmd_word_t            cmd_word;
    logic                           cmd_ack;
    logic [status_pkg::COUNT_W-1:0] rsp_data;
    status_pkg::link_status_t       link;
    logic                           dc_nreset;
    logic                           opt_nreset;
    logic                           status_led;

    int          cycle_count;
    int          errors;
    int          check_count;
    int          test_errors;
    int          raise_cycle;
    int          ack_edges;
    int          model_pll54;
    int          model_pll_hdmi;
    int          model_resync;
    int          toggle_wait;
    int          pulse_count;
    logic [2:0]  read_sel;
    logic [15:0] rsp;
    logic        led_start;
    string       name_q[$];
    logic [15:0] got_q[$];
    logic [15:0] exp_q[$];
    string       chk_name;
    logic [15:0] chk_got;
    logic [15:0] chk_exp;

    dc_control #(
        .HOLD_CYCLES   (HOLD_CYCLES),
        .SLOW_GLOW_BIT (SLOW_GLOW_BIT),
        .FAST_GLOW_BIT (4),
        .BLINK_BIT     (6)
    ) uut (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .cmd_req       (cmd_req),
        .cmd_word      (cmd_word),
        .cmd_ack       (cmd_ack),
        .rsp_data      (rsp_data),
        .link          (link),
        .dc_nreset     (dc_nreset),
        .opt_nreset    (opt_nreset),
        .status_led    (status_led)
    );

    bind dc_control dc_control_assert hs_checks (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .cmd_req       (cmd_req),
        .cmd_ack       (cmd_ack),
        .dc_nreset     (dc_nreset)
    );

    initial control_clock = 1'b0;
    always #2 control_clock = ~control_clock;

    always @(posedge control_clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped: no finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare process, drains results queued on the falling edge
    always @(posedge control_clock) begin
        while (got_q.size() > 0) begin
            chk_name = name_q.pop_front();
            chk_got  = got_q.pop_front();
            chk_exp  = exp_q.pop_front();
            check_count++;
            if (chk_got !== chk_exp) begin
                $display("[FAIL] %s: got 0x%04h, expected 0x%04h", chk_name, chk_got, chk_exp);
                errors++;
            end
        end
    end

    // model of the event counters
    function automatic logic [15:0] expect_count(input logic [2:0] sel);
        int count;
        case (sel)
            status_pkg::CNT_PLL54:    count = model_pll54;
            status_pkg::CNT_PLL_HDMI: count = model_pll_hdmi;
            status_pkg::CNT_RESYNC:   count = model_resync;
            default:                  count = 0;
        endcase
        // counters stop at all ones
        if (count > 16'hffff) begin
            count = 16'hffff;
        end
        return 16'(count);
    endfunction

    function automatic ctrl_pkg::cmd_word_t make_ctrl(
        input ctrl_pkg::opcode_t       op,
        input ctrl_pkg::reset_target_t target,
        input status_pkg::led_conf_t   conf
    );
        ctrl_pkg::cmd_word_t word;
        word                       = '0;
        word.opcode                = op;
        word.payload.ctrl.target   = target;
        word.payload.ctrl.led_conf = conf;
        return word;
    endfunction

    function automatic ctrl_pkg::cmd_word_t make_read(input logic [2:0] sel);
        ctrl_pkg::cmd_word_t word;
        word                          = '0;
        word.opcode                   = ctrl_pkg::OP_READ_COUNTER;
        word.payload.read.counter_sel = sel;
        return word;
    endfunction

    task automatic post_check(input string name, input logic [15:0] got, input logic [15:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
    endtask

    // four-phase host side, called on a falling edge
    task automatic send_command(
        input  ctrl_pkg::cmd_word_t word,
        output logic [15:0]         data,
        output int                  edges
    );
        raise_cycle = cycle_count;
        cmd_word    = word;
        cmd_req     = 1'b1;
        while (!cmd_ack) begin
            @(negedge control_clock);
        end
        edges   = cycle_count - raise_cycle;
        data    = rsp_data;
        cmd_req = 1'b0;
        while (cmd_ack) begin
            @(negedge control_clock);
        end
    endtask

    task automatic wait_release(input int from_cycle, input int expected, input string what);
        int guard;
        guard = 0;
        while (!(dc_nreset && opt_nreset) && guard < 4 * HOLD_CYCLES) begin
            @(negedge control_clock);
            guard++;
        end
        if (!(dc_nreset && opt_nreset)) begin
            $display("%s: reset outputs never returned high", what);
            errors++;
        end else begin
            post_check(what, 16'(cycle_count - from_cycle), 16'(expected));
        end
    endtask

    task automatic pulse_link(input int which);
        @(negedge control_clock);
        case (which)
            0:       link.pll54_locked    = 1'b0;
            1:       link.pll_hdmi_locked = 1'b0;
            default: link.resync          = 1'b1;
        endcase
        @(negedge control_clock);
        link.pll54_locked    = 1'b1;
        link.pll_hdmi_locked = 1'b1;
        link.resync          = 1'b0;
    endtask

    task automatic end_test(input string name);
        // one edge so the compare process has drained
        @(negedge control_clock);
        if (errors == test_errors) begin
            $display("[ OK ] %s", name);
        end else begin
            $display("[BAD ] %s, %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // host stimulus
    initial begin
        void'($urandom(8905));
        reset_dc   = 1'b1;
        cmd_req    = 1'b0;
        cmd_word   = '0;
        link       = '{pll54_locked: 1'b1, pll_hdmi_locked: 1'b1, resync: 1'b0,
                       force_generate: 1'b0, adv7513_ready: 1'b1};
        repeat (10) @(negedge control_clock);
        reset_dc = 1'b0;

        // reset release
        post_check("cmd_ack", 16'(cmd_ack), 16'h0);
        post_check("rsp_data", rsp_data, 16'h0);
        post_check("opt_nreset", 16'(opt_nreset), 16'h1);
        post_check("dc_nreset", 16'(dc_nreset), 16'h0);
        wait_release(cycle_count, HOLD_CYCLES, "dc_nreset release edges");
        end_test("reset release");

        // E is one edge after the raise, release HOLD_CYCLES+1 edges after E
        send_command(make_ctrl(ctrl_pkg::OP_RESET, ctrl_pkg::TGT_BOTH, status_pkg::LED_AUTO),
                     rsp, ack_edges);
        post_check("cmd_ack edges", 16'(ack_edges), 16'd2);
        post_check("rsp_data", rsp, 16'h0);
        post_check("dc_nreset", 16'(dc_nreset), 16'h0);
        post_check("opt_nreset", 16'(opt_nreset), 16'h0);
        wait_release(raise_cycle, HOLD_CYCLES + 2, "reset command release edges");
        end_test("handshake and reset command");

        // counter readback
        pulse_count = $urandom_range(20, 1);
        for (int i = 0; i < pulse_count; i++) begin
            pulse_link(0);
            model_pll54++;
        end
        pulse_count = $urandom_range(20, 1);
        for (int i = 0; i < pulse_count; i++) begin
            pulse_link(1);
            model_pll_hdmi++;
        end
        pulse_count = $urandom_range(20, 1);
        for (int i = 0; i < pulse_count; i++) begin
            pulse_link(2);
            model_resync++;
        end
        for (int sel = 0; sel < 4; sel++) begin
            // first pass reads select 5, which has no counter
            read_sel = (sel == 0) ? 3'd5 : 3'(sel - 1);
            send_command(make_read(read_sel), rsp, ack_edges);
            post_check($sformatf("rsp_data sel %0d", read_sel), rsp, expect_count(read_sel));
        end
        end_test("counter readback");

        // LED follows the selected reset
        send_command(make_ctrl(ctrl_pkg::OP_SET_LED, ctrl_pkg::TGT_NONE,
                               status_pkg::LED_CONSOLE), rsp, ack_edges);
        post_check("rsp_data set led", rsp, 16'h0);
        send_command(make_ctrl(ctrl_pkg::OP_RESET, ctrl_pkg::TGT_CONSOLE,
                               status_pkg::LED_AUTO), rsp, ack_edges);
        post_check("status_led console hold", 16'(status_led), 16'h0);
        wait_release(raise_cycle, HOLD_CYCLES + 2, "console release edges");
        post_check("status_led console free", 16'(status_led), 16'h1);
        send_command(make_ctrl(ctrl_pkg::OP_SET_LED, ctrl_pkg::TGT_NONE,
                               status_pkg::LED_OPTICAL), rsp, ack_edges);
        send_command(make_ctrl(ctrl_pkg::OP_RESET, ctrl_pkg::TGT_OPTICAL,
                               status_pkg::LED_AUTO), rsp, ack_edges);
        post_check("status_led optical hold", 16'(status_led), 16'h0);
        wait_release(raise_cycle, HOLD_CYCLES + 2, "optical release edges");
        post_check("status_led optical free", 16'(status_led), 16'h1);
        end_test("LED configuration");

        // auto mode priorities
        send_command(make_ctrl(ctrl_pkg::OP_SET_LED, ctrl_pkg::TGT_NONE,
                               status_pkg::LED_AUTO), rsp, ack_edges);
        link.pll_hdmi_locked = 1'b0;
        @(negedge control_clock);
        post_check("status_led hdmi unlocked", 16'(status_led), 16'h1);
        link.pll_hdmi_locked = 1'b1;
        @(negedge control_clock);
        post_check("status_led adv ready", 16'(status_led), 16'h0);
        link.adv7513_ready = 1'b0;
        @(negedge control_clock);
        led_start   = status_led;
        toggle_wait = 0;
        while (status_led == led_start && toggle_wait < 4 * GLOW_PERIOD) begin
            @(negedge control_clock);
            toggle_wait++;
        end
        if (status_led == led_start) begin
            $display("status_led never toggled in auto mode with adv7513_ready low");
            errors++;
        end
        end_test("LED auto mode");

        $display("%0d checks, %0d errors", check_count, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: dc_control.f
common/status_pkg.sv
common/ctrl_pkg.sv
reset/reset_hold.sv
status/lockloss_monitor.sv
status/status_led.sv
src/cmd_handler.sv
src/dc_control.sv
sim/dc_control_assert.sv
sim/tb_dc_control.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the dc_control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dc_control -f dc_control.f &&
sim_out=$(./obj_dir/Vtb_dc_control) &&
printf '%s\n' "$sim_out" &&
grep -qx "test passed" <<< "$sim_out" &&
echo "simulation ok" ||
{ echo "simulation FAILED"; exit 1; }
